// ==== dual_issue_core.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/pipe_ctrl.sv
hdl/issue_regs.sv
hdl/reg_file.sv
hdl/bypass_net.sv
hdl/exe_lane.sv
hdl/retire_regs.sv
hdl/dual_issue_core.sv
verif/dual_issue_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f dual_issue_core.f \
    --top-module dual_issue_core_tb --Mdir obj_dir -o dual_issue_core_sim \
    && ./obj_dir/dual_issue_core_sim | tee /dev/stderr \
    | grep "Simulation completed successfully" > /dev/null \
    && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/dual_issue_core_tb.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module dual_issue_core_tb;

    localparam int NUM_PAIRS      = 249;
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * 2 + 50;
    localparam int EXP_DEPTH      = TIMEOUT_CYCLES + 8;

    logic                  clk;
    logic                  rstn;
    logic                  issue_valid;
    core_pkg::issue_pair_t issue_pair;
    core_pkg::wb_port_t    wb0;
    core_pkg::wb_port_t    wb1;
    core_pkg::redirect_t   redirect;

    // entry n holds the expected outputs for the cycle after edge n
    core_pkg::wb_port_t  exp_wb0 [EXP_DEPTH];
    core_pkg::wb_port_t  exp_wb1 [EXP_DEPTH];
    core_pkg::redirect_t exp_rd  [EXP_DEPTH];
    // architectural register state in program order
    core_pkg::word_t     model_regs [`NUM_REGS];

    logic [31:0] lfsr_state;
    int          edge_cnt;
    int          err_cnt;
    int          live_cnt;
    int          kill_until;

    dual_issue_core dual_issue_core_i (
        .clk        (clk),
        .rstn       (rstn),
        .issue_valid(issue_valid),
        .issue_pair (issue_pair),
        .wb0        (wb0),
        .wb1        (wb1),
        .redirect   (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic is_cond(input core_pkg::alu_op_t op);
        return op inside {core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_blt, core_pkg::op_bge};
    endfunction

    function automatic logic wb_match(input core_pkg::wb_port_t got,
                                      input core_pkg::wb_port_t exp);
        return (got.valid == exp.valid) &&
               (!exp.valid || (got.addr == exp.addr && got.data == exp.data));
    endfunction

    function automatic logic rd_match(input core_pkg::redirect_t got,
                                      input core_pkg::redirect_t exp);
        return (got.taken == exp.taken) && (!exp.taken || got.target == exp.target);
    endfunction

    function automatic core_pkg::uop_t make_uop(input core_pkg::alu_op_t op,
                                                input core_pkg::src2_sel_t src2,
                                                input logic [4:0] rd, input logic [4:0] rj,
                                                input logic [4:0] rk, input core_pkg::word_t imm,
                                                input core_pkg::word_t pc);
        core_pkg::uop_t u;
        u.op   = op;
        u.src2 = src2;
        u.rd   = rd;
        u.rj   = rj;
        u.rk   = rk;
        u.imm  = imm;
        u.pc   = pc;
        return u;
    endfunction

    function automatic core_pkg::uop_t gen_uop(input logic [4:0] pool, input logic allow_br);
        core_pkg::uop_t u;
        logic [31:0] r;
        r = rand_bits(4);
        // jal and branches only when allowed and then at half rate
        if (r[3:0] >= 4'd11 && !(allow_br && rand_bits(1) == 32'd1)) begin
            r[3:0] = r[3:0] - 4'd11;
        end
        u.op = core_pkg::alu_op_t'(r[3:0]);
        r = rand_bits(2);
        u.src2 = (r[1:0] == 2'd3) ? core_pkg::src2_imm : core_pkg::src2_sel_t'(r[1:0]);
        r = rand_bits(15);
        u.rd = r[4:0] & pool;
        u.rj = r[9:5] & pool;
        u.rk = r[14:10] & pool;
        u.imm = rand_bits(32);
        r = rand_bits(30);
        u.pc = {r[29:0], 2'b00};
        return u;
    endfunction

    // lane 0 may not read what its older partner writes
    function automatic logic pair_conflict(input core_pkg::issue_pair_t p);
        logic l1_writes;
        l1_writes = !is_cond(p.lane1.op) && p.lane1.rd != '0;
        return l1_writes && (p.lane0.rj == p.lane1.rd || p.lane0.rk == p.lane1.rd ||
                             (is_cond(p.lane0.op) && p.lane0.rd == p.lane1.rd));
    endfunction

    function automatic void model_exec(input core_pkg::uop_t u, output core_pkg::word_t res,
                                       output logic taken, output logic wr);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t c;
        a = model_regs[u.rj];
        c = model_regs[u.rd];
        case (u.src2)
            core_pkg::src2_imm:  b = u.imm;
            core_pkg::src2_link: b = `LINK_OFFSET;
            default:             b = model_regs[u.rk];
        endcase
        res   = '0;
        taken = (u.op == core_pkg::op_jal);
        wr    = !is_cond(u.op) && u.rd != '0;
        case (u.op)
            core_pkg::op_add:  res = a + b;
            core_pkg::op_sub:  res = a - b;
            core_pkg::op_and:  res = a & b;
            core_pkg::op_or:   res = a | b;
            core_pkg::op_xor:  res = a ^ b;
            core_pkg::op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::op_sltu: res = (a < b) ? 32'd1 : 32'd0;
            core_pkg::op_sll:  res = a << b[4:0];
            core_pkg::op_srl:  res = a >> b[4:0];
            core_pkg::op_sra:  res = $signed(a) >>> b[4:0];
            core_pkg::op_lui:  res = u.imm;
            core_pkg::op_jal:  res = u.pc + `LINK_OFFSET;
            core_pkg::op_beq:  taken = (a == c);
            core_pkg::op_bne:  taken = (a != c);
            core_pkg::op_blt:  taken = ($signed(a) < $signed(c));
            default:           taken = ($signed(a) >= $signed(c));
        endcase
    endfunction

    // drive one pair and record what the DUT must show for it
    task automatic drive_pair(input logic valid, input core_pkg::issue_pair_t pair);
        int              s;
        core_pkg::word_t res1;
        core_pkg::word_t res0;
        logic            tk1;
        logic            tk0;
        logic            wr1;
        logic            wr0;
        @(posedge clk);
        #1;
        s = edge_cnt + 1;
        issue_valid = valid;
        issue_pair  = pair;
        if (valid && s > kill_until) begin
            model_exec(pair.lane1, res1, tk1, wr1);
            model_exec(pair.lane0, res0, tk0, wr0);
            // older lane 1 branch kills its partner
            if (tk1) wr0 = 1'b0;
            exp_rd[s + 1].taken  = tk1 | tk0;
            exp_rd[s + 1].target = tk1 ? pair.lane1.pc + pair.lane1.imm
                                       : pair.lane0.pc + pair.lane0.imm;
            exp_wb1[s + `WB_LATENCY] = {wr1, pair.lane1.rd, res1};
            exp_wb0[s + `WB_LATENCY] = {wr0, pair.lane0.rd, res0};
            if (wr1) model_regs[pair.lane1.rd] = res1;
            if (wr0) model_regs[pair.lane0.rd] = res0;
            if (tk1 || tk0) kill_until = s + 2;
            live_cnt++;
        end
    endtask

    task automatic run_random(input int count, input logic [4:0] pool, input logic allow_br);
        core_pkg::issue_pair_t p;
        for (int i = 0; i < count; i++) begin
            p.lane1 = gen_uop(pool, allow_br);
            p.lane0 = gen_uop(pool, allow_br);
            while (pair_conflict(p)) begin
                p.lane0 = gen_uop(pool, allow_br);
            end
            drive_pair(1'b1, p);
        end
    endtask

    task automatic run_directed();
        core_pkg::issue_pair_t p;
        p.lane1 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd1, 5'd0, 5'd0, 32'h5, 32'h0f0);
        p.lane0 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd2, 5'd0, 5'd0, 32'h5, 32'h0f4);
        drive_pair(1'b1, p);
        // taken beq in lane 0 while the partner still writes r3
        p.lane1 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd3, 5'd1, 5'd0, 32'h1, 32'h100);
        p.lane0 = make_uop(core_pkg::op_beq, core_pkg::src2_rk, 5'd2, 5'd1, 5'd0, 32'h40, 32'h104);
        drive_pair(1'b1, p);
        p.lane1 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd4, 5'd3, 5'd0, 32'h7, 32'h108);
        p.lane0 = make_uop(core_pkg::op_lui, core_pkg::src2_imm, 5'd5, 5'd0, 5'd0, 32'h99, 32'h10c);
        drive_pair(1'b1, p);
        drive_pair(1'b1, p);
        // both lanes jump and lane 1 wins
        p.lane1 = make_uop(core_pkg::op_jal, core_pkg::src2_link, 5'd6, 5'd0, 5'd0, 32'h80, 32'h200);
        p.lane0 = make_uop(core_pkg::op_jal, core_pkg::src2_link, 5'd7, 5'd0, 5'd0, 32'h10, 32'h204);
        drive_pair(1'b1, p);
        drive_pair(1'b1, p);
        drive_pair(1'b1, p);
        // untaken bne keeps everything behind it
        p.lane1 = make_uop(core_pkg::op_bne, core_pkg::src2_rk, 5'd2, 5'd1, 5'd0, 32'h20, 32'h280);
        p.lane0 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd8, 5'd3, 5'd0, 32'h1, 32'h284);
        drive_pair(1'b1, p);
        p.lane1 = make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd9, 5'd8, 5'd0, 32'h2, 32'h288);
        p.lane0 = make_uop(core_pkg::op_sub, core_pkg::src2_rk, 5'd10, 5'd8, 5'd1, 32'h0, 32'h28c);
        drive_pair(1'b1, p);
    endtask

    task automatic print_summary();
        $display("Summary: %0d pairs issued, %0d executed, %0d errors",
                 NUM_PAIRS, live_cnt, err_cnt);
    endtask

    reset_quiet : assert property (@(posedge clk)
        !rstn |-> (!wb0.valid && !wb1.valid && !redirect.taken))
    else begin
        err_cnt++;
        $display("Outputs were active while reset was asserted");
    end

    wb0_check : assert property (@(posedge clk) disable iff (!rstn)
        wb_match(wb0, exp_wb0[edge_cnt]))
    else begin
        err_cnt++;
        $display("Fail wb0 got %h expected %h", $sampled(wb0), exp_wb0[$sampled(edge_cnt)]);
    end

    wb1_check : assert property (@(posedge clk) disable iff (!rstn)
        wb_match(wb1, exp_wb1[edge_cnt]))
    else begin
        err_cnt++;
        $display("Fail wb1 got %h expected %h", $sampled(wb1), exp_wb1[$sampled(edge_cnt)]);
    end

    redirect_check : assert property (@(posedge clk) disable iff (!rstn)
        rd_match(redirect, exp_rd[edge_cnt]))
    else begin
        err_cnt++;
        $display("Fail redirect got %h expected %h",
                 $sampled(redirect), exp_rd[$sampled(edge_cnt)]);
    end

    initial begin
        wait (edge_cnt >= TIMEOUT_CYCLES);
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        lfsr_state  = 32'h8e8f;
        rstn        = 1'b0;
        // a jumping pair strobed during reset must not reach the outputs
        issue_valid = 1'b1;
        issue_pair  = {make_uop(core_pkg::op_jal, core_pkg::src2_link, 5'd1, 5'd0, 5'd0,
                                32'h40, 32'h300),
                       make_uop(core_pkg::op_add, core_pkg::src2_imm, 5'd2, 5'd0, 5'd0,
                                32'h3, 32'h304)};
        kill_until  = 0;
        for (int i = 0; i < EXP_DEPTH; i++) begin
            exp_wb0[i] = '0;
            exp_wb1[i] = '0;
            exp_rd[i]  = '0;
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rstn        = 1'b1;
        issue_valid = 1'b0;
        issue_pair  = '0;
        // wide register range first and then a small pool for dense forwarding
        run_random(40, 5'h1f, 1'b0);
        run_random(80, 5'h07, 1'b0);
        run_directed();
        run_random(120, 5'h07, 1'b1);
        repeat (`WB_LATENCY + 2) drive_pair(1'b0, '0);
        print_summary();
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  issue_valid,
    input  core_pkg::issue_pair_t issue_pair,
    output core_pkg::wb_port_t    wb0,
    output core_pkg::wb_port_t    wb1,
    output core_pkg::redirect_t   redirect
);

    core_pkg::lane_valid_t exe1_valid;
    core_pkg::lane_valid_t wb_valid;
    core_pkg::lane_valid_t br_taken;
    core_pkg::word_t       br_target0;
    core_pkg::word_t       br_target1;

    core_pkg::issue_pair_t id_pair;
    core_pkg::issue_pair_t exe0_pair;
    core_pkg::operands_t   rf_ops0;
    core_pkg::operands_t   rf_ops1;
    core_pkg::operands_t   exe0_ops0;
    core_pkg::operands_t   exe0_ops1;
    core_pkg::operands_t   fwd_ops0;
    core_pkg::operands_t   fwd_ops1;

    core_pkg::exe_result_t res0;
    core_pkg::exe_result_t res1;
    core_pkg::exe_result_t exe1_res0;
    core_pkg::exe_result_t exe1_res1;
    core_pkg::exe_result_t wb_res0;
    core_pkg::exe_result_t wb_res1;

    // early stage valids are only needed inside the control block
    pipe_ctrl pipe_ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .issue_valid(issue_valid),
        .br_taken   (br_taken),
        .br_target0 (br_target0),
        .br_target1 (br_target1),
        .id_valid   (),
        .exe0_valid (),
        .exe1_valid (exe1_valid),
        .wb_valid   (wb_valid),
        .redirect   (redirect)
    );

    issue_regs issue_regs_i (
        .clk        (clk),
        .rstn       (rstn),
        .issue_valid(issue_valid),
        .flush      (redirect.taken),
        .issue_pair (issue_pair),
        .rf_ops0    (rf_ops0),
        .rf_ops1    (rf_ops1),
        .id_pair    (id_pair),
        .exe0_pair  (exe0_pair),
        .exe0_ops0  (exe0_ops0),
        .exe0_ops1  (exe0_ops1)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rstn   (rstn),
        .id_pair(id_pair),
        .wb0    (wb0),
        .wb1    (wb1),
        .rf_ops0(rf_ops0),
        .rf_ops1(rf_ops1)
    );

    bypass_net bypass_net_i (
        .exe0_pair (exe0_pair),
        .exe0_ops0 (exe0_ops0),
        .exe0_ops1 (exe0_ops1),
        .exe1_res0 (exe1_res0),
        .exe1_res1 (exe1_res1),
        .wb_res0   (wb_res0),
        .wb_res1   (wb_res1),
        .exe1_valid(exe1_valid),
        .wb_valid  (wb_valid),
        .fwd_ops0  (fwd_ops0),
        .fwd_ops1  (fwd_ops1)
    );

    exe_lane exe_lane0 (
        .uop      (exe0_pair.lane0),
        .ops      (fwd_ops0),
        .res      (res0),
        .br_taken (br_taken[0]),
        .br_target(br_target0)
    );

    exe_lane exe_lane1 (
        .uop      (exe0_pair.lane1),
        .ops      (fwd_ops1),
        .res      (res1),
        .br_taken (br_taken[1]),
        .br_target(br_target1)
    );

    retire_regs retire_regs_i (
        .clk      (clk),
        .rstn     (rstn),
        .res0     (res0),
        .res1     (res1),
        .exe1_res0(exe1_res0),
        .exe1_res1(exe1_res1),
        .wb_res0  (wb_res0),
        .wb_res1  (wb_res1),
        .wb_valid (wb_valid),
        .wb0      (wb0),
        .wb1      (wb1)
    );

endmodule

// ==== hdl/retire_regs.sv ====
`timescale 1ns/1ps

module retire_regs (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_pkg::exe_result_t res0,
    input  core_pkg::exe_result_t res1,
    output core_pkg::exe_result_t exe1_res0,
    output core_pkg::exe_result_t exe1_res1,
    output core_pkg::exe_result_t wb_res0,
    output core_pkg::exe_result_t wb_res1,
    input  core_pkg::lane_valid_t wb_valid,
    output core_pkg::wb_port_t    wb0,
    output core_pkg::wb_port_t    wb1
);

    // EXE0-EXE1 then EXE1-WB, validity lives in pipe_ctrl
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exe1_res0 <= '0;
            exe1_res1 <= '0;
            wb_res0   <= '0;
            wb_res1   <= '0;
        end else begin
            exe1_res0 <= res0;
            exe1_res1 <= res1;
            wb_res0   <= exe1_res0;
            wb_res1   <= exe1_res1;
        end
    end

    // writeback ports
    always_comb begin
        wb0.valid = wb_valid[0] & wb_res0.wr_en;
        wb0.addr  = wb_res0.rd;
        wb0.data  = wb_res0.result;
        wb1.valid = wb_valid[1] & wb_res1.wr_en;
        wb1.addr  = wb_res1.rd;
        wb1.data  = wb_res1.result;
    end

endmodule

// ==== hdl/exe_lane.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module exe_lane (
    input  core_pkg::uop_t        uop,
    input  core_pkg::operands_t   ops,
    output core_pkg::exe_result_t res,
    output logic                  br_taken,
    output core_pkg::word_t       br_target
);

    localparam int SHAMT_W = $clog2(`XLEN);

    core_pkg::word_t op1;
    core_pkg::word_t op2;
    core_pkg::word_t alu_out;
    logic            is_cond_br;

    // operand select
    always_comb begin
        op1 = (uop.op == core_pkg::op_jal) ? uop.pc : ops.rj_val;
        case (uop.src2)
            core_pkg::src2_rk:   op2 = ops.rk_val;
            core_pkg::src2_imm:  op2 = uop.imm;
            core_pkg::src2_link: op2 = `LINK_OFFSET;
            default:             op2 = ops.rk_val;
        endcase
    end

    always_comb begin
        case (uop.op)
            core_pkg::op_add:  alu_out = op1 + op2;
            core_pkg::op_sub:  alu_out = op1 - op2;
            core_pkg::op_and:  alu_out = op1 & op2;
            core_pkg::op_or:   alu_out = op1 | op2;
            core_pkg::op_xor:  alu_out = op1 ^ op2;
            core_pkg::op_slt:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            core_pkg::op_sltu: alu_out = {{(`XLEN-1){1'b0}}, op1 < op2};
            core_pkg::op_sll:  alu_out = op1 << op2[SHAMT_W-1:0];
            core_pkg::op_srl:  alu_out = op1 >> op2[SHAMT_W-1:0];
            core_pkg::op_sra:  alu_out = $signed(op1) >>> op2[SHAMT_W-1:0];
            core_pkg::op_lui:  alu_out = uop.imm;
            // link value is always pc plus 4
            core_pkg::op_jal:  alu_out = op1 + `LINK_OFFSET;
            default:           alu_out = '0;
        endcase
    end

    // compare branches test rj against rd
    always_comb begin
        is_cond_br = 1'b0;
        br_taken   = 1'b0;
        case (uop.op)
            core_pkg::op_beq: begin
                is_cond_br = 1'b1;
                br_taken   = ops.rj_val == ops.rd_val;
            end
            core_pkg::op_bne: begin
                is_cond_br = 1'b1;
                br_taken   = ops.rj_val != ops.rd_val;
            end
            core_pkg::op_blt: begin
                is_cond_br = 1'b1;
                br_taken   = $signed(ops.rj_val) < $signed(ops.rd_val);
            end
            core_pkg::op_bge: begin
                is_cond_br = 1'b1;
                br_taken   = $signed(ops.rj_val) >= $signed(ops.rd_val);
            end
            core_pkg::op_jal: br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = uop.pc + uop.imm;

    assign res.result = alu_out;
    assign res.rd     = uop.rd;
    assign res.wr_en  = !is_cond_br && (uop.rd != '0);

endmodule

// ==== hdl/bypass_net.sv ====
`timescale 1ns/1ps

module bypass_net (
    input  core_pkg::issue_pair_t exe0_pair,
    input  core_pkg::operands_t   exe0_ops0,
    input  core_pkg::operands_t   exe0_ops1,
    input  core_pkg::exe_result_t exe1_res0,
    input  core_pkg::exe_result_t exe1_res1,
    input  core_pkg::exe_result_t wb_res0,
    input  core_pkg::exe_result_t wb_res1,
    input  core_pkg::lane_valid_t exe1_valid,
    input  core_pkg::lane_valid_t wb_valid,
    output core_pkg::operands_t   fwd_ops0,
    output core_pkg::operands_t   fwd_ops1
);

    // index 0 has the highest priority
    core_pkg::exe_result_t src_res [4];
    logic [3:0]            src_ok;

    assign src_res[0] = exe1_res0;
    assign src_res[1] = exe1_res1;
    assign src_res[2] = wb_res0;
    assign src_res[3] = wb_res1;

    assign src_ok = {wb_valid[1] & wb_res1.wr_en,
                     wb_valid[0] & wb_res0.wr_en,
                     exe1_valid[1] & exe1_res1.wr_en,
                     exe1_valid[0] & exe1_res0.wr_en};

    // walk from lowest priority up, the last match wins
    function automatic core_pkg::word_t pick(input core_pkg::reg_idx_t idx,
                                             input core_pkg::word_t base);
        core_pkg::word_t val;
        val = base;
        for (int i = 3; i >= 0; i--) begin
            if (src_ok[i] && idx != '0 && src_res[i].rd == idx) val = src_res[i].result;
        end
        return val;
    endfunction

    always_comb begin
        fwd_ops0.rj_val = pick(exe0_pair.lane0.rj, exe0_ops0.rj_val);
        fwd_ops0.rk_val = pick(exe0_pair.lane0.rk, exe0_ops0.rk_val);
        fwd_ops0.rd_val = pick(exe0_pair.lane0.rd, exe0_ops0.rd_val);
        fwd_ops1.rj_val = pick(exe0_pair.lane1.rj, exe0_ops1.rj_val);
        fwd_ops1.rk_val = pick(exe0_pair.lane1.rk, exe0_ops1.rk_val);
        fwd_ops1.rd_val = pick(exe0_pair.lane1.rd, exe0_ops1.rd_val);
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_pkg::issue_pair_t id_pair,
    input  core_pkg::wb_port_t    wb0,
    input  core_pkg::wb_port_t    wb1,
    output core_pkg::operands_t   rf_ops0,
    output core_pkg::operands_t   rf_ops1
);

    core_pkg::word_t regs [`NUM_REGS];

    // write-through, lane 0 is younger and wins on a shared index
    function automatic core_pkg::word_t read_port(input core_pkg::reg_idx_t idx);
        core_pkg::word_t val;
        val = regs[idx];
        if (wb1.valid && wb1.addr == idx) val = wb1.data;
        if (wb0.valid && wb0.addr == idx) val = wb0.data;
        if (idx == '0) val = '0;
        return val;
    endfunction

    always_comb begin
        rf_ops0.rj_val = read_port(id_pair.lane0.rj);
        rf_ops0.rk_val = read_port(id_pair.lane0.rk);
        rf_ops0.rd_val = read_port(id_pair.lane0.rd);
        rf_ops1.rj_val = read_port(id_pair.lane1.rj);
        rf_ops1.rk_val = read_port(id_pair.lane1.rk);
        rf_ops1.rd_val = read_port(id_pair.lane1.rd);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb1.valid && wb1.addr != '0) regs[wb1.addr] <= wb1.data;
            // second write lands last, so lane 0 wins
            if (wb0.valid && wb0.addr != '0) regs[wb0.addr] <= wb0.data;
        end
    end

    // rd 0 must already be filtered in the execution lanes
    no_write_to_zero : assert property (
        @(posedge clk) disable iff (!rstn)
        !((wb0.valid && wb0.addr == '0) || (wb1.valid && wb1.addr == '0))
    );

endmodule

// ==== hdl/issue_regs.sv ====
`timescale 1ns/1ps

module issue_regs (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  issue_valid,
    input  logic                  flush,
    input  core_pkg::issue_pair_t issue_pair,
    input  core_pkg::operands_t   rf_ops0,
    input  core_pkg::operands_t   rf_ops1,
    output core_pkg::issue_pair_t id_pair,
    output core_pkg::issue_pair_t exe0_pair,
    output core_pkg::operands_t   exe0_ops0,
    output core_pkg::operands_t   exe0_ops1
);

    // ID-REG
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_pair <= '0;
        end else if (flush) begin
            id_pair <= '0;
        end else if (issue_valid) begin
            id_pair <= issue_pair;
        end
    end

    // REG-EXE0, register read data is captured here
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exe0_pair <= '0;
            exe0_ops0 <= '0;
            exe0_ops1 <= '0;
        end else if (flush) begin
            exe0_pair <= '0;
            exe0_ops0 <= '0;
            exe0_ops1 <= '0;
        end else begin
            exe0_pair <= id_pair;
            exe0_ops0 <= rf_ops0;
            exe0_ops1 <= rf_ops1;
        end
    end

endmodule

// ==== hdl/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  issue_valid,
    input  core_pkg::lane_valid_t br_taken,
    input  core_pkg::word_t       br_target0,
    input  core_pkg::word_t       br_target1,
    output core_pkg::lane_valid_t id_valid,
    output core_pkg::lane_valid_t exe0_valid,
    output core_pkg::lane_valid_t exe1_valid,
    output core_pkg::lane_valid_t wb_valid,
    output core_pkg::redirect_t   redirect
);

    logic lane1_win;
    logic lane0_win;

    // only a live instruction in EXE0 may redirect
    assign lane1_win = br_taken[1] & exe0_valid[1];
    assign lane0_win = br_taken[0] & exe0_valid[0];

    // lane 1 is older and its branch outranks lane 0
    always_comb begin
        redirect.taken  = lane1_win | lane0_win;
        redirect.target = lane1_win ? br_target1 : br_target0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_valid   <= '0;
            exe0_valid <= '0;
            exe1_valid <= '0;
            wb_valid   <= '0;
        end else begin
            // an incoming pair is younger than the branch and is dropped
            if (issue_valid && !redirect.taken) begin
                id_valid <= 2'b11;
            end else begin
                id_valid <= 2'b00;
            end
            exe0_valid <= redirect.taken ? 2'b00 : id_valid;
            // taken lane 1 branch kills its lane 0 partner
            exe1_valid <= {exe0_valid[1], exe0_valid[0] & ~lane1_win};
            wb_valid   <= exe1_valid;
        end
    end

    // both younger pairs are gone for the two cycles after a redirect
    exe0_empty_after_redirect : assert property (
        @(posedge clk) disable iff (!rstn)
        ($past(redirect.taken) || $past(redirect.taken, 2)) |-> (exe0_valid == 2'b00)
    );

endmodule

// ==== hdl/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // one valid bit per lane, bit 1 is the older instruction
    typedef logic [1:0] lane_valid_t;

    typedef enum logic [3:0] {
        op_add, op_sub, op_and, op_or,
        op_xor, op_slt, op_sltu, op_sll,
        op_srl, op_sra, op_lui, op_jal,
        op_beq, op_bne, op_blt, op_bge
    } alu_op_t;

    typedef enum logic [1:0] {
        src2_rk, src2_imm, src2_link
    } src2_sel_t;

    typedef struct packed {
        alu_op_t   op;
        src2_sel_t src2;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        word_t     imm;
        word_t     pc;
    } uop_t;

    typedef struct packed {
        uop_t lane1;
        uop_t lane0;
    } issue_pair_t;

    // rd is also read as a source by the compare branches
    typedef struct packed {
        word_t rj_val;
        word_t rk_val;
        word_t rd_val;
    } operands_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     wr_en;
    } exe_result_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t addr;
        word_t    data;
    } wb_port_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and register file sizes
`define XLEN        32
`define NUM_REGS    32
`define REG_IDX_W   5

// return address step for jal
`define LINK_OFFSET 4

// edges from issue sampling until writeback is visible
`define WB_LATENCY  3

`endif
